// File: design/turbo_enc_pkg.sv
// block constants and shared types of the duobinary turbo encoder, imported by rtl and testbench
package turbo_enc_pkg;

  //--------------------------------------------------------------------
  // block constants
  //--------------------------------------------------------------------

  // couples per frame, fixed block size
  localparam int N_COUPLES  = 48;
  localparam int ADDR_W     = 6;

  // almost regular permutation constants
  localparam int PERM_P0    = 11;
  localparam int PERM_P1    = 24;
  localparam int PERM_P2    = 0;
  localparam int PERM_P3    = 24;

  // address to output word latency, in cycles
  localparam int PIPE_DEPTH = 3;
  // flush counter width, holds 0 .. PIPE_DEPTH-1
  localparam int FLUSH_W    = 2;

  //--------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------

  typedef logic [ADDR_W-1:0] addr_t;

  // one duobinary couple
  typedef struct packed {
    logic a;
    logic b;
  } couple_t;

  // 8-state coder register
  typedef struct packed {
    logic s1;
    logic s2;
    logic s3;
  } rsc_state_t;

  // coded output word, systematic bits on top
  typedef struct packed {
    logic a;
    logic b;
    logic y1;
    logic w1;
    logic y2;
    logic w2;
  } coded_couple_t;

  // per couple control travelling with the addresses
  typedef struct packed {
    logic val;
    logic sop;
    logic eop;
    logic swap;
  } couple_ctrl_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_FLUSH
  } enc_state_e;

endpackage

// File: design/enc_fsm.sv
// frame controller of the turbo encoder, starts the address run on a buffer-full strobe
module enc_fsm
  import turbo_enc_pkg::*;
(
  input  logic iclk,
  input  logic ireset,
  input  logic ibuf_full,
  input  logic last,
  output logic addr_clear,
  output logic addr_run,
  output logic orempty
);

  //--------------------------------------------------------------------
  // state and flush counter
  //--------------------------------------------------------------------

  enc_state_e         state;
  logic [FLUSH_W-1:0] flush_cnt;
  logic               start;

  // strobe only honored while idle
  assign start = (state == ST_IDLE) & ibuf_full;

  // start cycle already issues couple 0, so run covers it too
  assign addr_clear = start;
  // stop once the address generator presents the last couple
  assign addr_run   = start | ((state == ST_READ) & ~last);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= ST_IDLE;
      flush_cnt <= '0;
      orempty   <= 1'b0;
    end else begin
      // buffer may be refilled once the last address is out
      orempty <= (state == ST_READ) & last;
      case (state)
        ST_IDLE: begin
          if (ibuf_full) begin
            state <= ST_READ;
          end
        end
        ST_READ: begin
          if (last) begin
            state     <= ST_FLUSH;
            flush_cnt <= '0;
          end
        end
        ST_FLUSH: begin
          // wait out the datapath latency
          if (flush_cnt == FLUSH_W'(PIPE_DEPTH - 1)) begin
            state <= ST_IDLE;
          end else begin
            flush_cnt <= flush_cnt + 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: design/perm_addr_gen.sv
// natural and permuted read address generator with per couple framing control
module perm_addr_gen
  import turbo_enc_pkg::*;
(
  input  logic         iclk,
  input  logic         ireset,
  input  logic         iclear,
  input  logic         irun,
  output addr_t        oaddr,
  output addr_t        opaddr,
  output couple_ctrl_t octrl,
  output logic         olast
);

  //--------------------------------------------------------------------
  // couple index and running P0*j modulo N
  //--------------------------------------------------------------------

  addr_t      idx;
  addr_t      psum;
  addr_t      idx_cur;
  addr_t      psum_cur;
  addr_t      psum_next;
  addr_t      paddr_calc;
  logic [7:0] q;
  logic [7:0] praw;
  logic [6:0] pinc;

  // clear restarts the frame in the same cycle
  assign idx_cur  = iclear ? '0 : idx;
  assign psum_cur = iclear ? '0 : psum;

  // one subtraction brings the stepped sum back below N
  assign pinc      = {1'b0, psum_cur} + 7'(PERM_P0);
  assign psum_next = (pinc >= 7'(N_COUPLES)) ? ADDR_W'(pinc - 7'(N_COUPLES))
                                             : ADDR_W'(pinc);

  //--------------------------------------------------------------------
  // permuted address
  //--------------------------------------------------------------------

  always_comb begin
    // offset Q picked by j mod 4
    case (idx_cur[1:0])
      2'd0:    q = 8'd0;
      2'd1:    q = 8'(24 + PERM_P1);
      2'd2:    q = 8'(PERM_P2);
      default: q = 8'(24 + PERM_P3);
    endcase
    praw = {2'b00, psum_cur} + q + 8'd1;
    // at most two wraps for these ranges
    if (praw >= 8'(2 * N_COUPLES)) begin
      paddr_calc = ADDR_W'(praw - 8'(2 * N_COUPLES));
    end else if (praw >= 8'(N_COUPLES)) begin
      paddr_calc = ADDR_W'(praw - 8'(N_COUPLES));
    end else begin
      paddr_calc = ADDR_W'(praw);
    end
  end

  //--------------------------------------------------------------------
  // counters and control register
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      idx   <= '0;
      psum  <= '0;
      octrl <= '0;
    end else begin
      if (irun) begin
        idx  <= idx_cur + 1'b1;
        psum <= psum_next;
      end else if (iclear) begin
        idx  <= '0;
        psum <= '0;
      end
      octrl.val  <= irun;
      octrl.sop  <= irun & (idx_cur == '0);
      octrl.eop  <= irun & (idx_cur == ADDR_W'(N_COUPLES - 1));
      // even couples get a/b exchanged on the permuted side
      octrl.swap <= irun & ~idx_cur[0];
    end
  end

  // registered read addresses of the current couple
  always_ff @(posedge iclk) begin
    if (irun) begin
      oaddr  <= idx_cur;
      opaddr <= paddr_calc;
    end
  end

  // high while couple 47 is on the bus
  assign olast = octrl.val & octrl.eop;

endmodule

// File: design/rsc_coder.sv
// one 8-state duobinary recursive systematic coder, zero start at every sop
module rsc_coder
  import turbo_enc_pkg::*;
(
  input  logic    iclk,
  input  logic    ireset,
  input  logic    ival,
  input  logic    isop,
  input  couple_t idat,
  output logic    oy,
  output logic    ow
);

  rsc_state_t state;
  rsc_state_t s;
  logic       f;

  // frame start codes from the all-zero state
  assign s = isop ? '0 : state;

  // feedback bit
  assign f = idat.a ^ idat.b ^ s.s1 ^ s.s3;

  //--------------------------------------------------------------------
  // state register
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= '0;
    end else if (ival) begin
      state.s1 <= f;
      state.s2 <= s.s1 ^ idat.b;
      state.s3 <= s.s2 ^ idat.b;
    end
  end

  //--------------------------------------------------------------------
  // parity outputs
  //--------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (ival) begin
      oy <= f ^ s.s2 ^ s.s3;
      ow <= f ^ s.s3;
    end
  end

endmodule

// File: design/enc_datapath.sv
// turbo encoder datapath, two constituent coders and output word packing
module enc_datapath
  import turbo_enc_pkg::*;
(
  input  logic          iclk,
  input  logic          ireset,
  input  couple_ctrl_t  ictrl,
  input  couple_t       irdat,
  input  couple_t       irpdat,
  output logic          oval,
  output logic          osop,
  output logic          oeop,
  output coded_couple_t odat
);

  couple_ctrl_t ctrl_d1;
  couple_ctrl_t ctrl_d2;
  couple_t      perm_dat;
  couple_t      sys_d2;
  logic         y1;
  logic         w1;
  logic         y2;
  logic         w2;

  //--------------------------------------------------------------------
  // align control to the buffer read latency
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ctrl_d1 <= '0;
    end else begin
      ctrl_d1 <= ictrl;
    end
  end

  // a/b exchange on even permuted couples
  assign perm_dat = ctrl_d1.swap ? couple_t'({irpdat.b, irpdat.a}) : irpdat;

  //--------------------------------------------------------------------
  // constituent coders
  //--------------------------------------------------------------------

  rsc_coder u_rsc_nat (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (ctrl_d1.val),
    .isop   (ctrl_d1.sop),
    .idat   (irdat),
    .oy     (y1),
    .ow     (w1)
  );

  rsc_coder u_rsc_perm (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (ctrl_d1.val),
    .isop   (ctrl_d1.sop),
    .idat   (perm_dat),
    .oy     (y2),
    .ow     (w2)
  );

  //--------------------------------------------------------------------
  // match coder register stage
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ctrl_d2 <= '0;
    end else begin
      ctrl_d2 <= ctrl_d1;
    end
  end

  // systematic couple beside the coders
  always_ff @(posedge iclk) begin
    if (ctrl_d1.val) begin
      sys_d2 <= irdat;
    end
  end

  //--------------------------------------------------------------------
  // output word and framing
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
      osop <= 1'b0;
      oeop <= 1'b0;
    end else begin
      oval <= ctrl_d2.val;
      osop <= ctrl_d2.val & ctrl_d2.sop;
      oeop <= ctrl_d2.val & ctrl_d2.eop;
    end
  end

  always_ff @(posedge iclk) begin
    if (ctrl_d2.val) begin
      odat.a  <= sys_d2.a;
      odat.b  <= sys_d2.b;
      odat.y1 <= y1;
      odat.w1 <= w1;
      odat.y2 <= y2;
      odat.w2 <= w2;
    end
  end

endmodule

// File: design/turbo_enc_top.sv
// top level of the duobinary turbo encoder engine, frame read from an external buffer
module turbo_enc_top
  import turbo_enc_pkg::*;
(
  input  logic          iclk,
  input  logic          ireset,
  input  logic          ibuf_full,
  input  couple_t       irdat,
  input  couple_t       irpdat,
  output logic          orempty,
  output addr_t         oaddr,
  output addr_t         opaddr,
  output logic          oval,
  output logic          osop,
  output logic          oeop,
  output coded_couple_t odat
);

  logic         addr_clear;
  logic         addr_run;
  logic         addr_last;
  couple_ctrl_t addr_ctrl;

  //--------------------------------------------------------------------
  // frame controller
  //--------------------------------------------------------------------

  enc_fsm u_fsm (
    .iclk       (iclk),
    .ireset     (ireset),
    .ibuf_full  (ibuf_full),
    .last       (addr_last),
    .addr_clear (addr_clear),
    .addr_run   (addr_run),
    .orempty    (orempty)
  );

  //--------------------------------------------------------------------
  // read addresses, natural and permuted
  //--------------------------------------------------------------------

  perm_addr_gen u_addr_gen (
    .iclk   (iclk),
    .ireset (ireset),
    .iclear (addr_clear),
    .irun   (addr_run),
    .oaddr  (oaddr),
    .opaddr (opaddr),
    .octrl  (addr_ctrl),
    .olast  (addr_last)
  );

  //--------------------------------------------------------------------
  // coders and output packing
  //--------------------------------------------------------------------

  enc_datapath u_datapath (
    .iclk   (iclk),
    .ireset (ireset),
    .ictrl  (addr_ctrl),
    .irdat  (irdat),
    .irpdat (irpdat),
    .oval   (oval),
    .osop   (osop),
    .oeop   (oeop),
    .odat   (odat)
  );

endmodule

// File: sim/tb_turbo_enc.sv
// testbench for the turbo encoder top, replays trace frames and checks addresses, words, timing
module tb_turbo_enc
  import turbo_enc_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam string TRACE_FILE    = "sim/turbo_enc_trace.txt";
  localparam int    MAX_FRAMES    = 8;
  localparam int    FIRST_WORD    = PIPE_DEPTH + 1;
  localparam int    EMPTY_CYCLE   = N_COUPLES + 1;
  localparam int    QUIET_END     = 56;
  localparam int    FRAME_TIMEOUT = 200;

  logic          iclk;
  logic          ireset;
  logic          ibuf_full;
  couple_t       irdat;
  couple_t       irpdat;
  logic          orempty;
  addr_t         oaddr;
  addr_t         opaddr;
  logic          oval;
  logic          osop;
  logic          oeop;
  coded_couple_t odat;

  // trace contents
  int            n_frames;
  string         frame_name [MAX_FRAMES];
  couple_t       frame_in   [MAX_FRAMES][N_COUPLES];
  logic [5:0]    frame_exp  [MAX_FRAMES][N_COUPLES];

  // buffer model and bookkeeping
  couple_t       frame_mem  [N_COUPLES];
  addr_t         rd_addr;
  addr_t         rd_paddr;
  int            error_count;
  int            test_errors;
  int            tests_run;
  int            tests_failed;
  bit            aborted;
  int unsigned   rand_state;

  turbo_enc_top u_dut (
    .iclk      (iclk),
    .ireset    (ireset),
    .ibuf_full (ibuf_full),
    .irdat     (irdat),
    .irpdat    (irpdat),
    .orempty   (orempty),
    .oaddr     (oaddr),
    .opaddr    (opaddr),
    .oval      (oval),
    .osop      (osop),
    .oeop      (oeop),
    .odat      (odat)
  );

  // 20 ns clock
  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------

  function automatic int unsigned next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state >> 16;
  endfunction

  // permuted read address of couple j, almost regular rule
  function automatic int expected_paddr(input int j);
    int q;
    case (j % 4)
      0:       q = 0;
      1:       q = 24 + PERM_P1;
      2:       q = PERM_P2;
      default: q = 24 + PERM_P3;
    endcase
    return (PERM_P0 * j + q + 1) % N_COUPLES;
  endfunction

  function automatic int hex_digit(input byte ch);
    if (ch >= "0" && ch <= "9") return ch - "0";
    if (ch >= "a" && ch <= "f") return ch - "a" + 10;
    if (ch >= "A" && ch <= "F") return ch - "A" + 10;
    return -1;
  endfunction

  function automatic string strip_eol(input string s);
    int n;
    n = s.len();
    while (n > 0 && (s[n-1] == "\n" || s[n-1] == "\r" || s[n-1] == " ")) n--;
    return s.substr(0, n - 1);
  endfunction

  // unknown address before the first run reads as zero
  function automatic couple_t read_buf(input addr_t a);
    if ((^a) === 1'bx || a >= N_COUPLES) return '0;
    return frame_mem[a];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic begin_test();
    test_errors = error_count;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (error_count == test_errors) begin
      $display("test %-26s ok", name);
    end else begin
      tests_failed++;
      $display("test %-26s failed with %0d errors", name, error_count - test_errors);
    end
  endtask

  // --------------------------------------------------------------------
  // trace reader
  // --------------------------------------------------------------------

  // one hex digit per couple, other characters skipped
  task automatic parse_couples(input string s, input int f, output int cnt);
    int d;
    cnt = 0;
    for (int i = 0; i < s.len(); i++) begin
      d = hex_digit(s[i]);
      if (d >= 0) begin
        if (cnt < N_COUPLES) frame_in[f][cnt] = couple_t'(2'(d));
        cnt++;
      end
    end
  endtask

  // whitespace separated hex words
  task automatic parse_words(input string s, input int f, output int cnt);
    int d;
    int val;
    bit in_tok;
    cnt = 0;
    val = 0;
    in_tok = 0;
    for (int i = 0; i <= s.len(); i++) begin
      d = (i < s.len()) ? hex_digit(s[i]) : -1;
      if (d >= 0) begin
        val = val * 16 + d;
        in_tok = 1;
      end else if (in_tok) begin
        if (cnt < N_COUPLES) frame_exp[f][cnt] = 6'(val);
        cnt++;
        val = 0;
        in_tok = 0;
      end
    end
  endtask

  task automatic load_trace();
    int fd;
    int cnt;
    string line;
    string lines[$];
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("error: the trace file %s could not be opened", TRACE_FILE);
      error_count++;
      aborted = 1;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      line = strip_eol(line);
      if (line.len() > 0 && line[0] != "#") lines.push_back(line);
    end
    $fclose(fd);
    // name line, couple line, word line
    while (lines.size() >= 3 && n_frames < MAX_FRAMES) begin
      frame_name[n_frames] = lines.pop_front();
      parse_couples(lines.pop_front(), n_frames, cnt);
      if (cnt != N_COUPLES) begin
        $display("error: frame %s has %0d couples in the trace", frame_name[n_frames], cnt);
        error_count++;
      end
      parse_words(lines.pop_front(), n_frames, cnt);
      if (cnt != N_COUPLES) begin
        $display("error: frame %s has %0d expected words", frame_name[n_frames], cnt);
        error_count++;
      end
      n_frames++;
    end
    if (n_frames == 0) begin
      $display("error: the trace file holds no frame");
      error_count++;
      aborted = 1;
    end
  endtask

  // --------------------------------------------------------------------
  // buffer model, answers one cycle after the address
  // --------------------------------------------------------------------

  always begin
    @(negedge iclk);
    rd_addr  = oaddr;
    rd_paddr = opaddr;
    @(posedge iclk);
    #2;
    irdat  = read_buf(rd_addr);
    irpdat = read_buf(rd_paddr);
  end

  // --------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------

  task automatic check_reset_idle();
    begin_test();
    for (int i = 0; i < 20; i++) begin
      @(negedge iclk);
      check_value($sformatf("reset_idle oval cycle %0d", i), 0, oval);
      check_value($sformatf("reset_idle osop cycle %0d", i), 0, osop);
      check_value($sformatf("reset_idle oeop cycle %0d", i), 0, oeop);
      check_value($sformatf("reset_idle orempty cycle %0d", i), 0, orempty);
    end
    end_test("reset_idle");
  endtask

  // cycle c counts rising edges after the strobe; busy_at 0 means no extra strobe
  task automatic run_frame(input int f, input int busy_at);
    int c;
    int words;
    int first_val;
    int empty_cycle;
    int empty_pulses;
    bit done;
    int hits [N_COUPLES];
    string tname;
    tname = (busy_at > 0) ? {frame_name[f], "+busy_strobe"} : frame_name[f];
    begin_test();
    for (int i = 0; i < N_COUPLES; i++) begin
      frame_mem[i] = frame_in[f][i];
      hits[i] = 0;
    end
    words = 0;
    first_val = -1;
    empty_cycle = -1;
    empty_pulses = 0;
    done = 0;
    c = 0;
    @(posedge iclk);
    #2;
    ibuf_full = 1'b1;
    while (!(done && c >= QUIET_END) && c < FRAME_TIMEOUT) begin
      c++;
      @(posedge iclk);
      #2;
      // second strobe lands in the read phase
      ibuf_full = (c == busy_at);
      @(negedge iclk);
      if (c <= N_COUPLES) begin
        check_value($sformatf("%s oaddr %0d", tname, c - 1), c - 1, oaddr);
        check_value($sformatf("%s opaddr %0d", tname, c - 1), expected_paddr(c - 1), opaddr);
        if (opaddr < N_COUPLES) hits[opaddr]++;
      end else begin
        // no further addresses once the frame is read
        check_value($sformatf("%s oaddr hold cycle %0d", tname, c), N_COUPLES - 1, oaddr);
      end
      if (orempty === 1'b1) begin
        empty_pulses++;
        empty_cycle = c;
      end
      if (oval === 1'b1) begin
        if (first_val < 0) first_val = c;
        if (words < N_COUPLES) begin
          check_value($sformatf("%s word %0d", tname, words), frame_exp[f][words], odat);
          check_value($sformatf("%s osop word %0d", tname, words), words == 0, osop);
          check_value($sformatf("%s oeop word %0d", tname, words), words == N_COUPLES - 1, oeop);
          check_value($sformatf("%s cycle of word %0d", tname, words), words + FIRST_WORD, c);
        end
        words++;
        if (words >= N_COUPLES) done = 1;
      end else begin
        check_value($sformatf("%s osop idle cycle %0d", tname, c), 0, osop);
        check_value($sformatf("%s oeop idle cycle %0d", tname, c), 0, oeop);
      end
    end
    if (!done) begin
      $display("timeout: frame %s did not deliver all 48 words within %0d cycles",
               tname, FRAME_TIMEOUT);
      error_count++;
      aborted = 1;
    end else begin
      check_value({tname, " word count"}, N_COUPLES, words);
      check_value({tname, " orempty pulses"}, 1, empty_pulses);
      check_value({tname, " orempty cycle"}, EMPTY_CYCLE, empty_cycle);
      check_value({tname, " first oval cycle"}, FIRST_WORD, first_val);
      // each permuted index read exactly once
      for (int i = 0; i < N_COUPLES; i++) begin
        check_value($sformatf("%s opaddr %0d hits", tname, i), 1, hits[i]);
      end
    end
    end_test(tname);
  endtask

  // --------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------

  initial begin
    ireset = 1'b1;
    ibuf_full = 1'b0;
    irdat = '0;
    irpdat = '0;
    n_frames = 0;
    error_count = 0;
    tests_run = 0;
    tests_failed = 0;
    aborted = 0;
    rand_state = 18;
    load_trace();
    repeat (16) @(posedge iclk);
    #2;
    ireset = 1'b0;
    if (!aborted) check_reset_idle();
    for (int f = 0; f < n_frames && !aborted; f++) begin
      // idle gap of 0 to 7 cycles
      repeat (next_rand() % 8) @(posedge iclk);
      run_frame(f, (f == 0) ? 20 : 0);
    end
    $display("summary: %0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, error_count);
    if (error_count == 0 && !aborted) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sim/turbo_enc_trace.txt
# per frame: name line, then 48 couples as hex digits {a,b} in natural order,
# then 48 expected words in hex, {a,b,y1,w1,y2,w2}, first couple first
all_ones
33333333 33333333 33333333 33333333 33333333 33333333
30 3A 35 3F 3F 30 35 30 3A 35 3F 3F 30 35 30 3A 35 3F 3F 30 35 30 3A 35 3F 3F 30 35 30 3A 35 3F 3F 30 35 30 3A 35 3F 3F 30 35 30 3A 35 3F 3F 30
all_zeros
00000000 00000000 00000000 00000000 00000000 00000000
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
impulse_odd
00000000 00002000 00000000 00000000 00000000 00000000
00 03 03 01 01 02 03 02 00 03 01 01 2E 0F 06 04 0B 0D 09 02 0F 06 04 0B 0D 09 02 0F 06 04 0B 0D 09 02 0F 06 04 0B 0D 09 02 0F 06 04 0B 0D 09 02
impulse_swap
02000000 00000000 00000000 00000000 00000000 00000000
03 2D 0E 07 06 08 0F 09 01 0E 07 06 08 0F 09 01 0E 07 06 08 0F 09 01 0E 07 06 08 0F 09 01 0E 07 06 08 0F 09 01 0E 07 06 08 0F 09 01 0E 07 06 08

// File: tb.f
design/turbo_enc_pkg.sv
design/enc_fsm.sv
design/perm_addr_gen.sv
design/rsc_coder.sv
design/enc_datapath.sv
design/turbo_enc_top.sv
sim/tb_turbo_enc.sv

// File: Bender.yml
package:
  name: turbo_enc

sources:
  # rtl, package first
  - files:
      - design/turbo_enc_pkg.sv
      - design/enc_fsm.sv
      - design/perm_addr_gen.sv
      - design/rsc_coder.sv
      - design/enc_datapath.sv
      - design/turbo_enc_top.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_turbo_enc.sv
